/* Bender.yml */
package:
  name: gf_apb

sources:
  - src/gf_pkg.sv
  - src/gf_square.sv
  - src/gf_mult_serial.sv
  - src/gf_exec_unit.sv
  - src/gf_apb_regs.sv
  - src/gf_apb_top.sv
  - target: test
    files:
      - verification/gf_clk_gen.sv
      - verification/gf_props.sv
      - verification/gf_tb.sv

/* src/gf_apb_regs.sv */
`timescale 1ns/1ps

module gf_apb_regs #(
	parameter int unsigned M = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [gf_pkg::APB_AW-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      busy,
	input  gf_pkg::gf_rsp_t           rsp,
	output logic                      start,
	output gf_pkg::gf_cmd_t           cmd
);
	import gf_pkg::*;

	// Operands keep only the field bits.
	localparam logic [GF_MAX_M-1:0] OPND_MASK = GF_MAX_M'((1 << M) - 1);

	logic access;
	logic hit;
	logic busy_any;
	logic ctrl_refused;
	logic wr_en;

	// Zero wait states.
	assign pready = 1'b1;
	assign access = psel & penable;

	// A start already issued counts as busy too.
	assign busy_any = busy | start;

	// STATUS and RESULT do not accept writes.
	always_comb begin
		case (paddr)
			ADDR_OPA, ADDR_OPB, ADDR_CTRL: hit = 1'b1;
			ADDR_STATUS, ADDR_RESULT:      hit = ~pwrite;
			default:                       hit = 1'b0;
		endcase
	end

	assign ctrl_refused = pwrite && (paddr == ADDR_CTRL) && busy_any;
	assign pslverr      = access && (!hit || ctrl_refused);
	assign wr_en        = access && pwrite && hit && !ctrl_refused;

	// Register writes and start pulse.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd   <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_en) begin
				case (paddr)
					ADDR_OPA: cmd.a <= pwdata[GF_MAX_M-1:0] & OPND_MASK;
					ADDR_OPB: cmd.b <= pwdata[GF_MAX_M-1:0] & OPND_MASK;
					ADDR_CTRL: begin
						cmd.op <= gf_op_e'(pwdata[1:0]);
						start  <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Read mux.
	always_comb begin
		prdata = '0;
		case (paddr)
			ADDR_OPA:    prdata = 32'(cmd.a);
			ADDR_OPB:    prdata = 32'(cmd.b);
			ADDR_CTRL:   prdata = 32'(cmd.op);
			ADDR_STATUS: prdata = {30'd0, rsp.div_zero, busy_any};
			ADDR_RESULT: prdata = 32'(rsp.value);
			default:     prdata = '0;
		endcase
	end

endmodule

/* src/gf_apb_top.sv */
`timescale 1ns/1ps

module gf_apb_top #(
	parameter int unsigned M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [gf_pkg::APB_AW-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr
);
	import gf_pkg::*;

	logic    start;
	logic    busy;
	gf_cmd_t cmd;
	gf_rsp_t rsp;

	// Bus side.
	gf_apb_regs #(.M(M)) i_gf_apb_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.paddr  (paddr),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr),
		.busy   (busy),
		.rsp    (rsp),
		.start  (start),
		.cmd    (cmd)
	);

	// Arithmetic side.
	gf_exec_unit #(.M(M), .POLY(POLY)) i_gf_exec_unit (
		.clk  (clk),
		.rst_n(rst_n),
		.start(start),
		.cmd  (cmd),
		.busy (busy),
		.rsp  (rsp)
	);

endmodule

/* src/gf_exec_unit.sv */
`timescale 1ns/1ps

module gf_exec_unit #(
	parameter int unsigned M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  gf_pkg::gf_cmd_t cmd,
	output logic            busy,
	output gf_pkg::gf_rsp_t rsp
);
	import gf_pkg::*;

	localparam int unsigned CW = $clog2(M);

	gf_state_e     state;
	gf_op_e        op_q;
	logic [CW-1:0] step_cnt;
	logic          fin;
	logic          mul_start;
	logic          mul_done;
	logic          opnd_zero;
	logic [M-1:0]  a_q;
	logic [M-1:0]  pw;
	logic [M-1:0]  acc;
	logic [M-1:0]  sq_out;
	logic [M-1:0]  product;

	// Inverse of zero is undefined, so INV and DIV bail out early.
	assign opnd_zero = ((cmd.op == OP_INV) && (cmd.a[M-1:0] == '0)) ||
		((cmd.op == OP_DIV) && (cmd.b[M-1:0] == '0));

	assign busy = (state != ST_IDLE);

	// Squarer works on the running power.
	gf_square #(.M(M), .POLY(POLY)) i_gf_square (
		.in (pw),
		.out(sq_out)
	);

	// Multiplier always computes acc * pw.
	gf_mult_serial #(.M(M), .POLY(POLY)) i_gf_mult_serial (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (mul_start),
		.a      (acc),
		.b      (pw),
		.product(product),
		.done   (mul_done)
	);

	// Sequencer.
	// Fermat chain: a^-1 = a^2 * a^4 * ... * a^(2^(M-1)), one square and one multiply per step.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			op_q      <= OP_MUL;
			step_cnt  <= '0;
			fin       <= 1'b0;
			mul_start <= 1'b0;
			rsp       <= '0;
		end else begin
			mul_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						op_q         <= cmd.op;
						fin          <= 1'b0;
						step_cnt     <= CW'(M - 2);
						rsp.div_zero <= 1'b0;
						if (opnd_zero) begin
							state <= ST_DONE;
						end else if (cmd.op == OP_MUL) begin
							mul_start <= 1'b1;
							state     <= ST_MUL;
						end else begin
							state <= ST_SQR;
						end
					end
				end
				ST_SQR: begin
					if (op_q == OP_SQR) begin
						rsp.value <= GF_MAX_M'(sq_out);
						state     <= ST_IDLE;
					end else begin
						// Multiply by the freshly squared power.
						mul_start <= 1'b1;
						state     <= ST_MUL;
					end
				end
				ST_MUL: begin
					if (mul_done) begin
						if ((op_q == OP_MUL) || fin) begin
							rsp.value <= GF_MAX_M'(product);
							state     <= ST_IDLE;
						end else if (step_cnt != '0) begin
							step_cnt <= step_cnt - 1'b1;
							state    <= ST_SQR;
						end else if (op_q == OP_DIV) begin
							state <= ST_FINAL;
						end else begin
							rsp.value <= GF_MAX_M'(product);
							state     <= ST_IDLE;
						end
					end
				end
				ST_FINAL: begin
					// Dividend times inverse.
					fin       <= 1'b1;
					mul_start <= 1'b1;
					state     <= ST_MUL;
				end
				ST_DONE: begin
					rsp.value    <= '0;
					rsp.div_zero <= 1'b1;
					state        <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Operand path.
	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && start) begin
			a_q <= cmd.a[M-1:0];
			pw  <= (cmd.op == OP_MUL || cmd.op == OP_DIV) ? cmd.b[M-1:0] : cmd.a[M-1:0];
			acc <= (cmd.op == OP_MUL) ? cmd.a[M-1:0] : {{(M-1){1'b0}}, 1'b1};
		end else if (state == ST_SQR) begin
			pw <= sq_out;
		end else if ((state == ST_MUL) && mul_done) begin
			acc <= product;
		end else if (state == ST_FINAL) begin
			pw <= a_q;
		end
	end

endmodule

/* src/gf_mult_serial.sv */
`timescale 1ns/1ps

module gf_mult_serial #(
	parameter int unsigned M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic [M-1:0] product,
	output logic         done
);

	localparam int unsigned CW = $clog2(M);

	logic [M-1:0]  a_q;
	logic [M-1:0]  b_q;
	logic [M-1:0]  acc;
	logic [CW-1:0] idx;
	logic          running;

	// Step control.
	// The start cycle already handles bit M-1, so M-1 steps remain.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			idx     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				idx     <= CW'(M - 2);
			end else if (running) begin
				if (idx == '0) begin
					// Last bit folded in on this edge.
					running <= 1'b0;
					done    <= 1'b1;
				end else begin
					idx <= idx - 1'b1;
				end
			end
		end
	end

	// Horner scheme, MSB of a first.
	// Shift, reduce on carry out, then add b if the current bit of a is set.
	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= a;
			b_q <= b;
			acc <= {M{a[M-1]}} & b;
		end else if (running) begin
			acc <= {acc[M-2:0], 1'b0} ^ ({M{acc[M-1]}} & POLY) ^ ({M{a_q[idx]}} & b_q);
		end
	end

	// Holds after done until the next start.
	assign product = acc;

endmodule

/* src/gf_pkg.sv */
package gf_pkg;

	// Widest field the datapath structs can carry.
	localparam int unsigned GF_MAX_M = 16;

	// APB address width, enough for five word registers.
	localparam int unsigned APB_AW = 5;

	// Register offsets.
	localparam logic [APB_AW-1:0] ADDR_OPA    = 5'h00;
	localparam logic [APB_AW-1:0] ADDR_OPB    = 5'h04;
	localparam logic [APB_AW-1:0] ADDR_CTRL   = 5'h08;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 5'h0C;
	localparam logic [APB_AW-1:0] ADDR_RESULT = 5'h10;

	// Operations, encoded as written to CTRL bits 1:0.
	typedef enum logic [1:0] {
		OP_MUL = 2'd0,
		OP_SQR = 2'd1,
		OP_INV = 2'd2,
		OP_DIV = 2'd3
	} gf_op_e;

	// Sequencer states of the execution unit.
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_SQR   = 3'd1,
		ST_MUL   = 3'd2,
		ST_FINAL = 3'd3,
		ST_DONE  = 3'd4
	} gf_state_e;

	// Command from the register file.
	// Only the low M bits of a and b are meaningful.
	typedef struct packed {
		gf_op_e              op;
		logic [GF_MAX_M-1:0] a;
		logic [GF_MAX_M-1:0] b;
	} gf_cmd_t;

	// Response back to the register file.
	typedef struct packed {
		logic [GF_MAX_M-1:0] value;
		logic                div_zero;
	} gf_rsp_t;

endpackage

/* src/gf_square.sv */
`timescale 1ns/1ps

module gf_square #(
	parameter int unsigned M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input  logic [M-1:0] in,
	output logic [M-1:0] out
);

	// alpha^e reduced by the field polynomial, evaluated at elaboration.
	function automatic logic [M-1:0] alpha_pow(input int unsigned e);
		logic [M-1:0] r;
		int unsigned  n;
		r = {{(M-1){1'b0}}, 1'b1};
		for (n = 0; n < e; n++) begin
			r = {r[M-2:0], 1'b0} ^ ({M{r[M-1]}} & POLY);
		end
		return r;
	endfunction

	// Squaring is linear: a^2 = sum of a_i * alpha^(2i).
	// Row k gathers bit k of every alpha^(2i) term.
	for (genvar k = 0; k < M; k++) begin : g_row
		logic [M-1:0] col;
		for (genvar i = 0; i < M; i++) begin : g_term
			localparam logic [M-1:0] TERM = alpha_pow(2 * i);
			assign col[i] = TERM[k];
		end
		// Output bit is the parity of the selected input bits.
		assign out[k] = ^(in & col);
	end

endmodule

/* tb.f */
src/gf_pkg.sv
src/gf_square.sv
src/gf_mult_serial.sv
src/gf_exec_unit.sv
src/gf_apb_regs.sv
src/gf_apb_top.sv
verification/gf_clk_gen.sv
verification/gf_props.sv
verification/gf_tb.sv

/* verification/gf_clk_gen.sv */
`timescale 1ns/1ps

module gf_clk_gen #(
	parameter int unsigned PERIOD     = 40,
	parameter int unsigned RST_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	// Free-running clock, low at time zero.
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first cycles, released on a falling edge.
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* verification/gf_input.txt */
# name kind a b expected div_zero; a, b and expected in hex, GF(2^8) with x^8+x^4+x^3+x^2+1
# kind mul/sqr/inv/div runs one op, ovr adds a refused CTRL write, bad reads offset a, opa reads back
mul_gen      mul 02  80 1d 0
mul_ident    mul 57  01 57 0
mul_zero     mul 00  53 00 0
mul_red      mul 80  80 13 0
mul_alpha    mul 1d  3a 98 0
mul_wrap     mul cd  87 03 0
sqr_small    sqr 03  00 05 0
sqr_high     sqr 80  00 13 0
sqr_e8       sqr e8  00 ea 0
sqr_87       sqr 87  00 06 0
inv_one      inv 01  00 01 0
inv_two      inv 02  00 8e 0
inv_1d       inv 1d  00 83 0
inv_80       inv 80  00 1b 0
inv_zero     inv 00  00 00 1
div_basic    div 1d  02 80 0
div_alpha    div 03  80 2d 0
div_zero_num div 00  13 00 0
div_by_zero  div 05  00 00 1
div_clear    div 98  3a 1d 0
ovr_busy     ovr 98  3a 1d 0
bad_addr14   bad 14  00 01 0
bad_addr1c   bad 1c  00 01 0
opa_mask     opa 1ff 00 ff 0

/* verification/gf_props.sv */
`timescale 1ns/1ps

module gf_props #(
	parameter int unsigned M = 8
) (
	input logic              clk,
	input logic              rst_n,
	input logic              start,
	input logic              busy,
	input logic              mul_done,
	input gf_pkg::gf_state_e state
);
	import gf_pkg::*;

	// Longest operation, a full Fermat chain plus the final multiply.
	localparam int unsigned DIV_LAT = (M - 1) * (M + 2) + 1 + (M + 2);

	// A new command only reaches an idle sequencer.
	start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (state == ST_IDLE) && !busy)
		else $error("start seen while the execution unit was busy");

	// Every operation ends within the divide latency.
	busy_bound: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> ##[1:DIV_LAT] !busy)
		else $error("busy stayed high past the divide latency");

	// Multiplier done is one cycle wide.
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mul_done |=> !mul_done)
		else $error("multiplier done held for more than one cycle");

	// Unit comes out of reset idle.
	reset_idle: assert property (@(posedge clk)
		$rose(rst_n) |-> !busy)
		else $error("busy high right after reset");

endmodule

/* verification/gf_tb.sv */
`timescale 1ns/1ps

module tb_gf;
	import gf_pkg::*;

	localparam int unsigned M      = 8;
	localparam logic [M-1:0] POLY  = 8'h1D;
	localparam int unsigned PERIOD = 40;
	// Worst-case busy time of one divide, in cycles.
	localparam int unsigned DIV_LAT = (M - 1) * (M + 2) + 1 + (M + 2);

	logic              clk;
	logic              rst_n;
	logic [APB_AW-1:0] paddr;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;

	// Test vectors, one entry per data file line.
	string       names[$];
	string       kinds[$];
	logic [31:0] opnd_a[$];
	logic [31:0] opnd_b[$];
	logic [31:0] exp_val[$];
	logic        exp_dz[$];
	int          n_checks;
	int          n_errors;

	gf_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(2)) i_gf_clk_gen (.clk(clk), .rst_n(rst_n));

	gf_apb_top #(.M(M), .POLY(POLY)) i_gf_apb_top (
		.clk    (clk),
		.rst_n  (rst_n),
		.paddr  (paddr),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	// Sequencer assertions.
	bind gf_exec_unit gf_props #(.M(M)) i_gf_props (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.busy    (busy),
		.mul_done(mul_done),
		.state   (state)
	);

	// One APB transfer, setup phase then access phase.
	task automatic apb_xfer(input logic [APB_AW-1:0] addr, input logic wr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		// Zero wait states, so the access completes on the next rising edge.
		#1;
		rdata = prdata;
		err   = pslverr;
		if (pready !== 1'b1) begin
			n_errors++;
			$display("pready was low in the access phase at offset %0h", addr);
		end
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input string name, input logic [APB_AW-1:0] addr,
			input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(addr, 1'b1, data, rdata, err);
		if (err) begin
			n_errors++;
			$display("%s: write to offset %0h was refused with pslverr", name, addr);
		end
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// CTRL encoding of a kind column; an overlap test runs a divide.
	function automatic logic [1:0] op_code(input string kind);
		if (kind == "mul") return OP_MUL;
		else if (kind == "sqr") return OP_SQR;
		else if (kind == "inv") return OP_INV;
		else return OP_DIV;
	endfunction

	task automatic load_vectors();
		int          fd;
		int          cnt;
		int          dz;
		string       line;
		string       name;
		string       kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] e;
		fd = $fopen("verification/gf_input.txt", "r");
		if (fd == 0) begin
			n_errors++;
			$display("could not open verification/gf_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			cnt = $fgets(line, fd);
			// Lines starting with # are comments.
			if ((cnt > 0) && (line.getc(0) != "#")) begin
				cnt = $sscanf(line, "%s %s %h %h %h %d", name, kind, a, b, e, dz);
				if (cnt == 6) begin
					names.push_back(name);
					kinds.push_back(kind);
					opnd_a.push_back(a);
					opnd_b.push_back(b);
					exp_val.push_back(e);
					exp_dz.push_back(dz[0]);
				end
			end
		end
		$fclose(fd);
		if (names.size() == 0) begin
			n_errors++;
			$display("no test vectors were loaded");
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, errors %0d", n_checks, n_errors);
	endtask

	// Hard stop scaled to the number of vectors.
	task automatic watchdog();
		int unsigned limit;
		limit = (names.size() * DIV_LAT * 4 + 200) * PERIOD;
		#(limit);
		n_errors++;
		$display("timeout, the run did not finish within %0d ns", limit);
		report_counts();
		$display("sim failed");
		$finish;
	endtask

	// Operands, command, optional refused command, poll, then result and flag.
	task automatic run_op(input int i, input logic overlap);
		logic [31:0] rdata;
		logic        err;
		int          idle;
		write_reg(names[i], ADDR_OPA, opnd_a[i]);
		write_reg(names[i], ADDR_OPB, opnd_b[i]);
		write_reg(names[i], ADDR_CTRL, 32'(op_code(kinds[i])));
		if (overlap) begin
			apb_xfer(ADDR_CTRL, 1'b1, 32'(OP_MUL), rdata, err);
			expect_equal({names[i], " pslverr"}, 32'd1, 32'(err));
		end
		rdata = 32'd1;
		while (rdata[0]) begin
			idle = $urandom_range(3);
			repeat (idle) @(negedge clk);
			apb_xfer(ADDR_STATUS, 1'b0, '0, rdata, err);
		end
		apb_xfer(ADDR_RESULT, 1'b0, '0, rdata, err);
		expect_equal(names[i], exp_val[i], rdata);
		apb_xfer(ADDR_STATUS, 1'b0, '0, rdata, err);
		expect_equal({names[i], " div_zero"}, 32'(exp_dz[i]), 32'(rdata[1]));
	endtask

	initial begin
		logic [31:0] rdata;
		logic        err;
		void'($urandom(39));
		paddr    = '0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		pwdata   = '0;
		n_checks = 0;
		n_errors = 0;
		load_vectors();
		fork
			watchdog();
		join_none
		@(posedge rst_n);
		for (int i = 0; i < names.size(); i++) begin
			if (kinds[i] == "bad") begin
				// Unmapped read, the expected column holds pslverr.
				apb_xfer(opnd_a[i][APB_AW-1:0], 1'b0, '0, rdata, err);
				expect_equal(names[i], exp_val[i], 32'(err));
			end else if (kinds[i] == "opa") begin
				write_reg(names[i], ADDR_OPA, opnd_a[i]);
				apb_xfer(ADDR_OPA, 1'b0, '0, rdata, err);
				expect_equal(names[i], exp_val[i], rdata);
			end else begin
				run_op(i, kinds[i] == "ovr");
			end
		end
		report_counts();
		if ((n_errors == 0) && (n_checks > 0)) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
